// ==== vlog.f ====
rv_pkg.sv
data_forwarding.sv
alu.sv
reg_file.sv
mul_fsm.sv
mul_datapath.sv
exec_pipeline.sv
exec_pipeline_props.sv
exec_pipeline_tb.sv

// ==== Bender.yml ====
package:
  name: exec_pipeline

sources:
  - rv_pkg.sv
  - data_forwarding.sv
  - alu.sv
  - reg_file.sv
  - mul_fsm.sv
  - mul_datapath.sv
  - exec_pipeline.sv
  - target: simulation
    files:
      - exec_pipeline_props.sv
      - exec_pipeline_tb.sv

// ==== exec_pipeline_tb.sv ====
`timescale 1ns/10ps
`default_nettype none

module exec_pipeline_tb import rv_pkg::*; ();

    localparam int MAX_SLOTS = 160;
    localparam int MAX_ROWS  = 64;
    localparam int DRAIN     = 6;

    logic     clk;
    logic     rst;
    logic     issue_valid;
    instr_u   issue_instr;
    logic     wb_valid;
    reg_idx_t wb_rd;
    word_t    wb_data;
    logic     aux_wb_valid;
    reg_idx_t aux_wb_rd;
    word_t    aux_wb_data;
    logic     st_valid;
    word_t    st_addr;
    word_t    st_data;
    logic     br_valid;
    logic     br_taken;

    // stimulus table, one row per issue plus idle gap
    instr_u   tbl_instr [MAX_ROWS];
    int       tbl_gap [MAX_ROWS];
    int       n_rows;
    int       n_slots;

    // reference register state, program order
    word_t    mregs [32];

    // expected strobes indexed by slot
    logic     exp_wb_v [MAX_SLOTS];
    reg_idx_t exp_wb_rd [MAX_SLOTS];
    word_t    exp_wb_d [MAX_SLOTS];
    logic     exp_aux_v [MAX_SLOTS];
    reg_idx_t exp_aux_rd [MAX_SLOTS];
    word_t    exp_aux_d [MAX_SLOTS];
    logic     exp_st_v [MAX_SLOTS];
    word_t    exp_st_a [MAX_SLOTS];
    word_t    exp_st_d [MAX_SLOTS];
    logic     exp_br_v [MAX_SLOTS];
    logic     exp_br_t [MAX_SLOTS];

    integer   seed;
    int       slot;
    int       next_slot;
    logic     running;
    int       cycles;
    int       limit;

    exec_pipeline UUT (
        .clk         (clk),
        .rst         (rst),
        .issue_valid (issue_valid),
        .issue_instr (issue_instr),
        .wb_valid    (wb_valid),
        .wb_rd       (wb_rd),
        .wb_data     (wb_data),
        .aux_wb_valid(aux_wb_valid),
        .aux_wb_rd   (aux_wb_rd),
        .aux_wb_data (aux_wb_data),
        .st_valid    (st_valid),
        .st_addr     (st_addr),
        .st_data     (st_data),
        .br_valid    (br_valid),
        .br_taken    (br_taken)
    );

    // 4 ns clock
    initial clk = 1'b0;
    always #2 clk = ~clk;

    function automatic instr_u enc_r(input logic [6:0] f7, input reg_idx_t rs2,
                                     input reg_idx_t rs1, input logic [2:0] f3,
                                     input reg_idx_t rd);
        instr_u ins;
        ins.r_fmt.funct7 = f7;
        ins.r_fmt.rs2    = rs2;
        ins.r_fmt.rs1    = rs1;
        ins.r_fmt.funct3 = f3;
        ins.r_fmt.rd     = rd;
        ins.r_fmt.opcode = OP_R_FORMAT;
        return ins;
    endfunction

    function automatic instr_u enc_i(input logic [11:0] imm, input reg_idx_t rs1,
                                     input logic [2:0] f3, input reg_idx_t rd);
        instr_u ins;
        ins.i_fmt.imm    = imm;
        ins.i_fmt.rs1    = rs1;
        ins.i_fmt.funct3 = f3;
        ins.i_fmt.rd     = rd;
        ins.i_fmt.opcode = OP_I_FORMAT;
        return ins;
    endfunction

    function automatic instr_u enc_s(input logic [11:0] imm, input reg_idx_t rs2,
                                     input reg_idx_t rs1);
        instr_u ins;
        ins.s_fmt.imm_hi = imm[11:5];
        ins.s_fmt.rs2    = rs2;
        ins.s_fmt.rs1    = rs1;
        ins.s_fmt.funct3 = 3'b010;
        ins.s_fmt.imm_lo = imm[4:0];
        ins.s_fmt.opcode = OP_S_FORMAT;
        return ins;
    endfunction

    function automatic instr_u enc_b(input logic [2:0] f3, input reg_idx_t rs1,
                                     input reg_idx_t rs2);
        instr_u ins;
        // offset has no effect, no fetch here
        ins.b_fmt.imm_12   = 1'b0;
        ins.b_fmt.imm_10_5 = '0;
        ins.b_fmt.rs2      = rs2;
        ins.b_fmt.rs1      = rs1;
        ins.b_fmt.funct3   = f3;
        ins.b_fmt.imm_4_1  = 4'd4;
        ins.b_fmt.imm_11   = 1'b0;
        ins.b_fmt.opcode   = OP_B_FORMAT;
        return ins;
    endfunction

    function automatic logic [11:0] rnd12();
        return 12'($random(seed));
    endfunction

    // rv32i integer semantics by funct3
    function automatic word_t int_op(input logic [2:0] f3, input logic alt,
                                     input logic is_reg, input word_t a, input word_t b);
        case (f3)
            3'd0:    return (is_reg && alt) ? a - b : a + b;
            3'd1:    return a << b[4:0];
            3'd2:    return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            3'd3:    return (a < b) ? 32'd1 : 32'd0;
            3'd4:    return a ^ b;
            3'd5:    return alt ? word_t'($signed(a) >>> b[4:0]) : a >> b[4:0];
            3'd6:    return a | b;
            default: return a & b;
        endcase
    endfunction

    function automatic logic br_cond(input logic [2:0] f3, input word_t a, input word_t b);
        case (f3)
            3'd0:    return a == b;
            3'd1:    return a != b;
            3'd4:    return $signed(a) < $signed(b);
            3'd5:    return $signed(a) >= $signed(b);
            3'd6:    return a < b;
            3'd7:    return a >= b;
            default: return 1'b0;
        endcase
    endfunction

    // model one issue at slot s, fill expected strobes
    task automatic model_issue(input instr_u ins, input int s);
        word_t a;
        word_t b;
        word_t imm_i;
        word_t imm_s;
        word_t r;
        a     = mregs[ins.r_fmt.rs1];
        b     = mregs[ins.r_fmt.rs2];
        imm_i = {{20{ins.i_fmt.imm[11]}}, ins.i_fmt.imm};
        imm_s = {{20{ins.s_fmt.imm_hi[6]}}, ins.s_fmt.imm_hi, ins.s_fmt.imm_lo};
        case (ins.r_fmt.opcode)
            OP_R_FORMAT: begin
                if (ins.r_fmt.funct7 == FUNCT7_MULDIV) begin
                    r = a * b;
                    exp_aux_v[s + 34]  = 1'b1;
                    exp_aux_rd[s + 34] = ins.r_fmt.rd;
                    exp_aux_d[s + 34]  = r;
                end else begin
                    r = int_op(ins.r_fmt.funct3, ins.r_fmt.funct7[5], 1'b1, a, b);
                    exp_wb_v[s + 3]  = 1'b1;
                    exp_wb_rd[s + 3] = ins.r_fmt.rd;
                    exp_wb_d[s + 3]  = r;
                end
                if (ins.r_fmt.rd != '0)
                    mregs[ins.r_fmt.rd] = r;
            end
            OP_I_FORMAT: begin
                // srai flag sits in imm bit 10
                r = int_op(ins.i_fmt.funct3, ins.i_fmt.imm[10], 1'b0, a, imm_i);
                exp_wb_v[s + 3]  = 1'b1;
                exp_wb_rd[s + 3] = ins.i_fmt.rd;
                exp_wb_d[s + 3]  = r;
                if (ins.i_fmt.rd != '0)
                    mregs[ins.i_fmt.rd] = r;
            end
            OP_S_FORMAT: begin
                exp_st_v[s + 2] = 1'b1;
                exp_st_a[s + 2] = a + imm_s;
                exp_st_d[s + 2] = b;
            end
            default: begin
                exp_br_v[s + 2] = 1'b1;
                exp_br_t[s + 2] = br_cond(ins.b_fmt.funct3, a, b);
            end
        endcase
    endtask

    task automatic add_row(input instr_u ins, input int gap);
        tbl_instr[n_rows] = ins;
        tbl_gap[n_rows]   = gap;
        model_issue(ins, n_slots);
        n_rows++;
        n_slots += 1 + gap;
    endtask

    task automatic fail_now();
        $display("SOME TESTS FAILED");
        $fatal(1);
    endtask

    task automatic check_word(input string name, input word_t got, input word_t exp);
        if (got !== exp) begin
            $display("[ERROR] %s: got 0x%h, expected 0x%h (slot %0d)", name, got, exp, slot);
            fail_now();
        end
    endtask

    task automatic check_idx(input string name, input reg_idx_t got, input reg_idx_t exp);
        if (got !== exp) begin
            $display("[ERROR] %s: got 0x%h, expected 0x%h (slot %0d)", name, got, exp, slot);
            fail_now();
        end
    endtask

    task automatic check_bit(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            $display("[ERROR] %s: got 0x%h, expected 0x%h (slot %0d)", name, got, exp, slot);
            fail_now();
        end
    endtask

    // one issue slot, inputs change on the rising edge
    task automatic drive_slot(input logic v, input instr_u ins);
        @(posedge clk);
        slot = next_slot;
        next_slot++;
        running = 1'b1;
        issue_valid <= v;
        issue_instr <= ins;
    endtask

    // outputs settled by the falling edge
    always @(negedge clk) begin
        if (UUT.u_props.fail_count != 0) begin
            $display("a bound property on the pipeline failed");
            fail_now();
        end
        if (running) begin
            check_bit("wb_valid", wb_valid, exp_wb_v[slot]);
            if (exp_wb_v[slot]) begin
                check_idx("wb_rd", wb_rd, exp_wb_rd[slot]);
                check_word("wb_data", wb_data, exp_wb_d[slot]);
            end
            check_bit("aux_wb_valid", aux_wb_valid, exp_aux_v[slot]);
            if (exp_aux_v[slot]) begin
                check_idx("aux_wb_rd", aux_wb_rd, exp_aux_rd[slot]);
                check_word("aux_wb_data", aux_wb_data, exp_aux_d[slot]);
            end
            check_bit("st_valid", st_valid, exp_st_v[slot]);
            if (exp_st_v[slot]) begin
                check_word("st_addr", st_addr, exp_st_a[slot]);
                check_word("st_data", st_data, exp_st_d[slot]);
            end
            check_bit("br_valid", br_valid, exp_br_v[slot]);
            if (exp_br_v[slot])
                check_bit("br_taken", br_taken, exp_br_t[slot]);
        end
    end

    always @(posedge clk) begin
        if (!rst) begin
            cycles++;
            if (cycles > limit) begin
                $display("timeout: run did not end within %0d cycles", limit);
                fail_now();
            end
        end
    end

    initial begin
        rst         = 1'b1;
        issue_valid = 1'b0;
        issue_instr = '0;
        seed        = 16865;
        running     = 1'b0;
        slot        = 0;
        next_slot   = 0;
        cycles      = 0;
        n_rows      = 0;
        n_slots     = 0;
        limit       = MAX_SLOTS;
        for (int i = 0; i < 32; i++)
            mregs[i] = '0;
        for (int i = 0; i < MAX_SLOTS; i++) begin
            exp_wb_v[i]  = 1'b0;
            exp_aux_v[i] = 1'b0;
            exp_st_v[i]  = 1'b0;
            exp_br_v[i]  = 1'b0;
        end

        // mem then wb forwarding chain
        add_row(enc_i(12'd5, 5'd1, F3_ADD, 5'd1), 0);
        add_row(enc_i(12'd7, 5'd1, F3_ADD, 5'd2), 0);
        add_row(enc_r(7'h00, 5'd2, 5'd1, F3_ADD, 5'd3), 0);
        add_row(enc_r(7'h20, 5'd1, 5'd3, F3_ADD, 5'd4), 0);
        // write to x0, next row must still read zero
        add_row(enc_i(12'd99, 5'd1, F3_ADD, 5'd0), 0);
        // x3 three issues back, from the register file
        add_row(enc_r(7'h00, 5'd3, 5'd0, F3_ADD, 5'd6), 0);
        add_row(enc_i(12'd3, 5'd1, F3_SLL, 5'd7), 0);
        add_row(enc_i(12'hfec, 5'd0, F3_ADD, 5'd8), 0);
        add_row(enc_i(12'h402, 5'd8, F3_SR, 5'd9), 0);
        add_row(enc_r(7'h00, 5'd1, 5'd8, F3_SLT, 5'd12), 0);
        add_row(enc_r(7'h00, 5'd1, 5'd8, F3_SLTU, 5'd13), 0);
        add_row(enc_r(7'h00, 5'd1, 5'd8, F3_SR, 5'd14), 0);
        // stores, negative and positive offsets
        add_row(enc_s(12'hffc, 5'd3, 5'd2), 0);
        add_row(enc_s(12'h7f0, 5'd13, 5'd14), 0);
        // every branch condition
        add_row(enc_b(F3_BEQ, 5'd2, 5'd4), 0);
        add_row(enc_b(F3_BNE, 5'd2, 5'd4), 0);
        add_row(enc_b(F3_BLT, 5'd8, 5'd1), 0);
        add_row(enc_b(F3_BGE, 5'd8, 5'd1), 0);
        add_row(enc_b(F3_BLTU, 5'd8, 5'd1), 0);
        add_row(enc_b(F3_BGEU, 5'd8, 5'd1), 0);
        // random mul operands built from 12-bit pieces
        add_row(enc_i(rnd12(), 5'd0, F3_ADD, 5'd10), 0);
        add_row(enc_i(12'd20, 5'd10, F3_SLL, 5'd10), 0);
        add_row(enc_i(rnd12(), 5'd10, F3_XOR, 5'd10), 0);
        add_row(enc_i(rnd12(), 5'd0, F3_ADD, 5'd11), 0);
        add_row(enc_i(12'd16, 5'd11, F3_SLL, 5'd11), 0);
        add_row(enc_i(rnd12(), 5'd11, F3_OR, 5'd11), 0);
        // mul, independent work, then aux consumer in the done cycle
        add_row(enc_r(FUNCT7_MULDIV, 5'd11, 5'd10, F3_ADD, 5'd5), 0);
        add_row(enc_i(12'd1, 5'd1, F3_ADD, 5'd16), 0);
        add_row(enc_r(7'h00, 5'd2, 5'd16, F3_ADD, 5'd17), 30);
        add_row(enc_r(7'h00, 5'd10, 5'd5, F3_ADD, 5'd18), 2);
        // second mul, alu write to the same rd lands with aux
        add_row(enc_r(FUNCT7_MULDIV, 5'd10, 5'd11, F3_ADD, 5'd19), 30);
        add_row(enc_i(12'd100, 5'd1, F3_ADD, 5'd19), 4);
        add_row(enc_r(7'h00, 5'd0, 5'd19, F3_ADD, 5'd20), 0);
        add_row(enc_s(12'd0, 5'd20, 5'd1), 0);
        limit = n_slots + 40;

        repeat (10) @(posedge clk);
        rst <= 1'b0;

        for (int k = 0; k < n_rows; k++) begin
            drive_slot(1'b1, tbl_instr[k]);
            for (int g = 0; g < tbl_gap[k]; g++)
                drive_slot(1'b0, '0);
        end
        // let the last strobes come out
        for (int d = 0; d < DRAIN; d++)
            drive_slot(1'b0, '0);

        @(negedge clk);
        if (UUT.u_props.fail_count == 0) begin
            $display("ALL TESTS PASSED");
            $finish;
        end else begin
            $display("a bound property on the pipeline failed");
            fail_now();
        end
    end

endmodule

`default_nettype wire

// ==== exec_pipeline_props.sv ====
`timescale 1ns/10ps
`default_nettype none

module exec_pipeline_props import rv_pkg::*; (
    input logic     clk,
    input logic     rst,
    input logic     issue_valid,
    input logic     ex_valid,
    input instr_u   ex_instr,
    input logic     mul_start,
    input logic     mul_busy,
    input logic     aux_wb_valid,
    input reg_idx_t aux_wb_rd,
    input logic     wb_valid,
    input logic     st_valid,
    input logic     br_valid
);

    logic mul_running;
    logic ex_reads_rs2;
    logic ex_reads_mul_rd;
    int   fail_count = 0;

    // older mul still stepping, its result not out yet
    assign mul_running = mul_busy && !aux_wb_valid;

    // i format holds immediate bits in the rs2 slot
    assign ex_reads_rs2 = (ex_instr.r_fmt.opcode == OP_R_FORMAT) ||
                          (ex_instr.r_fmt.opcode == OP_S_FORMAT) ||
                          (ex_instr.r_fmt.opcode == OP_B_FORMAT);
    // rd of the running mul is latched once it leaves ex
    assign ex_reads_mul_rd = (aux_wb_rd != '0) &&
                             ((ex_instr.r_fmt.rs1 == aux_wb_rd) ||
                              (ex_reads_rs2 && (ex_instr.r_fmt.rs2 == aux_wb_rd)));

    // issue rules seen in the ex cycle, where operands are read
    a_mul_overlap: assert property (@(posedge clk) disable iff (rst)
        mul_start |-> !mul_running)
        else begin
            fail_count++;
            $error("mul issued while another mul is in flight");
        end

    a_mul_rd_read: assert property (@(posedge clk) disable iff (rst)
        ex_valid |-> !(mul_running && ex_reads_mul_rd))
        else begin
            fail_count++;
            $error("issue reads the rd of a mul in flight");
        end

    // aux result one cycle after the last step
    a_aux_strobe: assert property (@(posedge clk) disable iff (rst)
        aux_wb_valid |-> $past(mul_start, MUL_STEPS + 1))
        else begin
            fail_count++;
            $error("aux write-back strobe without a matching mul start");
        end

    // each strobe traces back to exactly one issue
    a_wb_strobe: assert property (@(posedge clk) disable iff (rst)
        wb_valid |-> $past(issue_valid, 3))
        else begin
            fail_count++;
            $error("write-back strobe without a matching issue");
        end

    a_st_strobe: assert property (@(posedge clk) disable iff (rst)
        st_valid |-> $past(issue_valid, 2))
        else begin
            fail_count++;
            $error("store strobe without a matching issue");
        end

    a_br_strobe: assert property (@(posedge clk) disable iff (rst)
        br_valid |-> $past(issue_valid, 2))
        else begin
            fail_count++;
            $error("branch strobe without a matching issue");
        end

    a_reset_quiet: assert property (@(posedge clk)
        rst && $past(rst) |-> !(wb_valid || st_valid || br_valid || aux_wb_valid))
        else begin
            fail_count++;
            $error("output strobe active during reset");
        end

endmodule

bind exec_pipeline exec_pipeline_props u_props (.*);

`default_nettype wire

// ==== exec_pipeline.sv ====
`timescale 1ns/10ps
`default_nettype none

module exec_pipeline import rv_pkg::*; (
    input  logic     clk,
    input  logic     rst,
    input  logic     issue_valid,
    input  instr_u   issue_instr,
    output logic     wb_valid,
    output reg_idx_t wb_rd,
    output word_t    wb_data,
    output logic     aux_wb_valid,
    output reg_idx_t aux_wb_rd,
    output word_t    aux_wb_data,
    output logic     st_valid,
    output word_t    st_addr,
    output word_t    st_data,
    output logic     br_valid,
    output logic     br_taken
);

    // ex stage
    logic       ex_valid;
    instr_u     ex_instr;
    logic [6:0] ex_opcode;
    logic [2:0] ex_funct3;
    logic       ex_alt;
    logic       is_r;
    logic       is_i;
    logic       is_s;
    logic       is_b;
    logic       is_mul;
    logic [3:0] alu_op;
    word_t      imm;
    word_t      rdata1;
    word_t      rdata2;
    logic [1:0] forward_a;
    logic [1:0] forward_b;
    word_t      opnd_a;
    word_t      opnd_b;
    word_t      alu_b;
    word_t      alu_result;
    logic       alu_taken;

    // multiplier handshake
    logic mul_start;
    logic mul_step;
    // multiplier occupancy, watched by the issue checks
    logic mul_busy;

    // mem stage
    logic     mem_wr;
    reg_idx_t mem_rd;
    word_t    mem_result;

    always_ff @(posedge clk) begin
        if (rst)
            ex_valid <= 1'b0;
        else
            ex_valid <= issue_valid;
    end

    always_ff @(posedge clk) begin
        if (issue_valid)
            ex_instr <= issue_instr;
    end

    // decode via union, common fields line up
    assign ex_opcode = ex_instr.r_fmt.opcode;
    assign ex_funct3 = ex_instr.r_fmt.funct3;
    // funct7 bit 5, also imm bit 10 for srai
    assign ex_alt    = ex_instr.r_fmt.funct7[5];
    assign is_r      = (ex_opcode == OP_R_FORMAT);
    assign is_i      = (ex_opcode == OP_I_FORMAT);
    assign is_s      = (ex_opcode == OP_S_FORMAT);
    assign is_b      = (ex_opcode == OP_B_FORMAT);
    assign is_mul    = is_r && (ex_instr.r_fmt.funct7 == FUNCT7_MULDIV);

    always_comb begin
        if (is_s || is_b) begin
            // address add; branch result unused
            alu_op = ALU_ADD;
        end else begin
            case (ex_funct3)
                F3_ADD:  alu_op = (is_r && ex_alt) ? ALU_SUB : ALU_ADD;
                F3_SLL:  alu_op = ALU_SLL;
                F3_SLT:  alu_op = ALU_SLT;
                F3_SLTU: alu_op = ALU_SLTU;
                F3_XOR:  alu_op = ALU_XOR;
                F3_SR:   alu_op = ex_alt ? ALU_SRA : ALU_SRL;
                F3_OR:   alu_op = ALU_OR;
                default: alu_op = ALU_AND;
            endcase
        end
    end

    // sign extended immediates
    always_comb begin
        if (is_s)
            imm = {{20{ex_instr.s_fmt.imm_hi[6]}}, ex_instr.s_fmt.imm_hi,
                   ex_instr.s_fmt.imm_lo};
        else
            imm = {{20{ex_instr.i_fmt.imm[11]}}, ex_instr.i_fmt.imm};
    end

    function automatic word_t fwd_mux(input logic [1:0] sel, input word_t reg_val);
        word_t v;
        case (sel)
            FWD_MEM: v = mem_result;
            FWD_WB:  v = wb_data;
            FWD_AUX: v = aux_wb_data;
            default: v = reg_val;
        endcase
        return v;
    endfunction

    always_comb begin
        opnd_a = fwd_mux(forward_a, rdata1);
        opnd_b = fwd_mux(forward_b, rdata2);
    end

    // i and s take the immediate
    assign alu_b = (is_r || is_b) ? opnd_b : imm;

    assign mul_start = ex_valid && is_mul;

    data_forwarding u_fwd (
        .reg_write_mem   (mem_wr),
        .reg_write_wb    (wb_valid),
        .reg_write_wb_aux(aux_wb_valid),
        .rd_mem          (mem_rd),
        .rd_wb           (wb_rd),
        .rd_wb_aux       (aux_wb_rd),
        .instr_ex        (ex_instr),
        .forward_a       (forward_a),
        .forward_b       (forward_b)
    );

    reg_file u_rf (
        .clk      (clk),
        .rst      (rst),
        .rs1      (ex_instr.r_fmt.rs1),
        .rs2      (ex_instr.r_fmt.rs2),
        .rdata1   (rdata1),
        .rdata2   (rdata2),
        .we       (wb_valid),
        .waddr    (wb_rd),
        .wdata    (wb_data),
        .we_aux   (aux_wb_valid),
        .waddr_aux(aux_wb_rd),
        .wdata_aux(aux_wb_data)
    );

    alu u_alu (
        .op    (alu_op),
        .a     (opnd_a),
        .b     (alu_b),
        .funct3(ex_funct3),
        .result(alu_result),
        .taken (alu_taken)
    );

    mul_fsm u_mul_fsm (
        .clk  (clk),
        .rst  (rst),
        .start(mul_start),
        .busy (mul_busy),
        .step (mul_step),
        .done (aux_wb_valid)
    );

    mul_datapath u_mul_dp (
        .clk    (clk),
        .start  (mul_start),
        .step   (mul_step),
        .op_a   (opnd_a),
        .op_b   (opnd_b),
        .rd_in  (ex_instr.r_fmt.rd),
        .product(aux_wb_data),
        .rd_out (aux_wb_rd)
    );

    // mem stage, mul leaves the pipe here
    always_ff @(posedge clk) begin
        if (rst) begin
            mem_wr   <= 1'b0;
            st_valid <= 1'b0;
            br_valid <= 1'b0;
        end else begin
            mem_wr   <= ex_valid && (is_i || (is_r && !is_mul));
            st_valid <= ex_valid && is_s;
            br_valid <= ex_valid && is_b;
        end
    end

    always_ff @(posedge clk) begin
        mem_rd     <= ex_instr.r_fmt.rd;
        mem_result <= alu_result;
        st_data    <= opnd_b;
        br_taken   <= alu_taken;
    end

    // store address is the alu sum
    assign st_addr = mem_result;

    // wb stage, register file written at its end
    always_ff @(posedge clk) begin
        if (rst)
            wb_valid <= 1'b0;
        else
            wb_valid <= mem_wr;
    end

    always_ff @(posedge clk) begin
        wb_rd   <= mem_rd;
        wb_data <= mem_result;
    end

endmodule

`default_nettype wire

// ==== mul_datapath.sv ====
`timescale 1ns/10ps
`default_nettype none

module mul_datapath import rv_pkg::*; (
    input  logic     clk,
    input  logic     start,
    input  logic     step,
    input  word_t    op_a,
    input  word_t    op_b,
    input  reg_idx_t rd_in,
    output word_t    product,
    output reg_idx_t rd_out
);

    // multiplicand moves left, multiplier right
    word_t mcand;
    word_t mplier;
    word_t acc;

    always_ff @(posedge clk) begin
        if (start) begin
            mcand  <= op_a;
            mplier <= op_b;
            acc    <= '0;
            rd_out <= rd_in;
        end else if (step) begin
            // add partial product when lsb set
            if (mplier[0])
                acc <= acc + mcand;
            mcand  <= mcand << 1;
            mplier <= mplier >> 1;
        end
    end

    // upper half of the product is never formed
    assign product = acc;

endmodule

`default_nettype wire

// ==== mul_fsm.sv ====
`timescale 1ns/10ps
`default_nettype none

module mul_fsm import rv_pkg::*; (
    input  logic clk,
    input  logic rst,
    input  logic start,
    output logic busy,
    output logic step,
    output logic done
);

    logic [1:0] state;
    logic [4:0] count;

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= ST_IDLE;
            count <= '0;
        end else begin
            case (state)
                ST_IDLE: begin
                    if (start)
                        state <= ST_RUN;
                    count <= '0;
                end
                ST_RUN: begin
                    count <= count + 5'd1;
                    // last step taken on this edge
                    if (count == 5'(MUL_STEPS - 1))
                        state <= ST_DONE;
                end
                ST_DONE: begin
                    // result out this cycle, next mul may start
                    state <= start ? ST_RUN : ST_IDLE;
                    count <= '0;
                end
                default: state <= ST_IDLE;
            endcase
        end
    end

    assign busy = (state != ST_IDLE);
    assign step = (state == ST_RUN);
    // one cycle, DONE is never held
    assign done = (state == ST_DONE);

endmodule

`default_nettype wire

// ==== reg_file.sv ====
`timescale 1ns/10ps
`default_nettype none

module reg_file import rv_pkg::*; (
    input  logic     clk,
    input  logic     rst,
    input  reg_idx_t rs1,
    input  reg_idx_t rs2,
    output word_t    rdata1,
    output word_t    rdata2,
    input  logic     we,
    input  reg_idx_t waddr,
    input  word_t    wdata,
    input  logic     we_aux,
    input  reg_idx_t waddr_aux,
    input  word_t    wdata_aux
);

    // x0 has no storage
    word_t regs [1:31];

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 1; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else begin
            if (we_aux && (waddr_aux != '0))
                regs[waddr_aux] <= wdata_aux;
            // later assignment, so wb wins a same-rd collision
            if (we && (waddr != '0))
                regs[waddr] <= wdata;
        end
    end

    // combinational read, no internal bypass
    assign rdata1 = (rs1 == '0) ? '0 : regs[rs1];
    assign rdata2 = (rs2 == '0) ? '0 : regs[rs2];

endmodule

`default_nettype wire

// ==== alu.sv ====
`timescale 1ns/10ps
`default_nettype none

module alu import rv_pkg::*; (
    input  logic [3:0] op,
    input  word_t      a,
    input  word_t      b,
    input  logic [2:0] funct3,
    output word_t      result,
    output logic       taken
);

    logic [4:0] shamt;
    logic       lt_s;
    logic       lt_u;

    // only low five bits shift
    assign shamt = b[4:0];
    // shared by slt and the branch compare
    assign lt_s  = $signed(a) < $signed(b);
    assign lt_u  = a < b;

    always_comb begin
        case (op)
            ALU_ADD:  result = a + b;
            ALU_SUB:  result = a - b;
            ALU_AND:  result = a & b;
            ALU_OR:   result = a | b;
            ALU_XOR:  result = a ^ b;
            ALU_SLL:  result = a << shamt;
            ALU_SRL:  result = a >> shamt;
            ALU_SRA:  result = $signed(a) >>> shamt;
            ALU_SLT:  result = {31'b0, lt_s};
            ALU_SLTU: result = {31'b0, lt_u};
            default:  result = a + b;
        endcase
    end

    // branch condition, same cycle as the result
    always_comb begin
        case (funct3)
            F3_BEQ:  taken = (a == b);
            F3_BNE:  taken = (a != b);
            F3_BLT:  taken = lt_s;
            F3_BGE:  taken = !lt_s;
            F3_BLTU: taken = lt_u;
            F3_BGEU: taken = !lt_u;
            default: taken = 1'b0;
        endcase
    end

endmodule

`default_nettype wire

// ==== data_forwarding.sv ====
`timescale 1ns/10ps
`default_nettype none

module data_forwarding import rv_pkg::*; (
    input  logic       reg_write_mem,
    input  logic       reg_write_wb,
    input  logic       reg_write_wb_aux,
    input  reg_idx_t   rd_mem,
    input  reg_idx_t   rd_wb,
    input  reg_idx_t   rd_wb_aux,
    input  instr_u     instr_ex,
    output logic [1:0] forward_a,
    output logic [1:0] forward_b
);

    // youngest producer first, then wb, then the multiplier
    function automatic logic [1:0] fwd_sel(input reg_idx_t rs);
        logic [1:0] sel;
        // x0 always reads as zero, never forwarded
        if (rs == '0)
            sel = FWD_REG;
        else if (reg_write_mem && (rd_mem == rs))
            sel = FWD_MEM;
        else if (reg_write_wb && (rd_wb == rs))
            sel = FWD_WB;
        else if (reg_write_wb_aux && (rd_wb_aux == rs))
            sel = FWD_AUX;
        else
            sel = FWD_REG;
        return sel;
    endfunction

    always_comb begin
        case (instr_ex.r_fmt.opcode)
            OP_R_FORMAT: begin
                forward_a = fwd_sel(instr_ex.r_fmt.rs1);
                forward_b = fwd_sel(instr_ex.r_fmt.rs2);
            end
            OP_B_FORMAT: begin
                forward_a = fwd_sel(instr_ex.b_fmt.rs1);
                forward_b = fwd_sel(instr_ex.b_fmt.rs2);
            end
            OP_S_FORMAT: begin
                // b side carries the store data
                forward_a = fwd_sel(instr_ex.s_fmt.rs1);
                forward_b = fwd_sel(instr_ex.s_fmt.rs2);
            end
            OP_I_FORMAT: begin
                // rs2 slot holds immediate bits here
                forward_a = fwd_sel(instr_ex.i_fmt.rs1);
                forward_b = FWD_REG;
            end
            default: begin
                forward_a = FWD_REG;
                forward_b = FWD_REG;
            end
        endcase
    end

endmodule

`default_nettype wire

// ==== rv_pkg.sv ====
`default_nettype none

package rv_pkg;

    // major opcodes, rv32i base
    localparam logic [6:0] OP_R_FORMAT = 7'b0110011;
    localparam logic [6:0] OP_I_FORMAT = 7'b0010011;
    localparam logic [6:0] OP_S_FORMAT = 7'b0100011;
    localparam logic [6:0] OP_B_FORMAT = 7'b1100011;

    // m extension marker in funct7
    localparam logic [6:0] FUNCT7_MULDIV = 7'b0000001;

    // funct3 of integer ops
    localparam logic [2:0] F3_ADD  = 3'b000;
    localparam logic [2:0] F3_SLL  = 3'b001;
    localparam logic [2:0] F3_SLT  = 3'b010;
    localparam logic [2:0] F3_SLTU = 3'b011;
    localparam logic [2:0] F3_XOR  = 3'b100;
    localparam logic [2:0] F3_SR   = 3'b101;
    localparam logic [2:0] F3_OR   = 3'b110;
    localparam logic [2:0] F3_AND  = 3'b111;

    // funct3 of branches
    localparam logic [2:0] F3_BEQ  = 3'b000;
    localparam logic [2:0] F3_BNE  = 3'b001;
    localparam logic [2:0] F3_BLT  = 3'b100;
    localparam logic [2:0] F3_BGE  = 3'b101;
    localparam logic [2:0] F3_BLTU = 3'b110;
    localparam logic [2:0] F3_BGEU = 3'b111;

    // alu operation codes
    localparam logic [3:0] ALU_ADD  = 4'd0;
    localparam logic [3:0] ALU_SUB  = 4'd1;
    localparam logic [3:0] ALU_AND  = 4'd2;
    localparam logic [3:0] ALU_OR   = 4'd3;
    localparam logic [3:0] ALU_XOR  = 4'd4;
    localparam logic [3:0] ALU_SLL  = 4'd5;
    localparam logic [3:0] ALU_SLT  = 4'd6;
    localparam logic [3:0] ALU_SLTU = 4'd7;
    localparam logic [3:0] ALU_SRL  = 4'd8;
    localparam logic [3:0] ALU_SRA  = 4'd9;

    // operand source selects
    localparam logic [1:0] FWD_REG = 2'b00;
    localparam logic [1:0] FWD_WB  = 2'b01;
    localparam logic [1:0] FWD_MEM = 2'b10;
    localparam logic [1:0] FWD_AUX = 2'b11;

    // shift-add multiplier
    localparam int MUL_STEPS = 32;
    localparam logic [1:0] ST_IDLE = 2'd0;
    localparam logic [1:0] ST_RUN  = 2'd1;
    localparam logic [1:0] ST_DONE = 2'd2;

    typedef logic [4:0]  reg_idx_t;
    typedef logic [31:0] word_t;

    // one instruction word, four field layouts
    typedef union packed {
        struct packed {
            logic [6:0] funct7;
            reg_idx_t   rs2;
            reg_idx_t   rs1;
            logic [2:0] funct3;
            reg_idx_t   rd;
            logic [6:0] opcode;
        } r_fmt;
        struct packed {
            logic [11:0] imm;
            reg_idx_t    rs1;
            logic [2:0]  funct3;
            reg_idx_t    rd;
            logic [6:0]  opcode;
        } i_fmt;
        struct packed {
            logic [6:0] imm_hi;
            reg_idx_t   rs2;
            reg_idx_t   rs1;
            logic [2:0] funct3;
            logic [4:0] imm_lo;
            logic [6:0] opcode;
        } s_fmt;
        struct packed {
            logic       imm_12;
            logic [5:0] imm_10_5;
            reg_idx_t   rs2;
            reg_idx_t   rs1;
            logic [2:0] funct3;
            logic [3:0] imm_4_1;
            logic       imm_11;
            logic [6:0] opcode;
        } b_fmt;
    } instr_u;

endpackage

`default_nettype wire
